// File: all.f
+incdir+testbench
source/i2si_audio_pkg.sv
source/i2si_ctrl_pkg.sv
source/i2si_pin_sync.sv
source/i2si_deserializer.sv
source/i2si_frame_source.sv
source/i2si_fifo.sv
source/i2si.sv
testbench/tb_i2si.sv

// File: source/i2si.sv
`timescale 1ns/1ps

module i2si
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i2si_sck,          // I2S pins from the external transmitter
    input  logic                  i2si_ws,
    input  logic                  i2si_sd,
    input  logic                  rf_i2si_en,        // Capture enable
    input  logic                  rf_bist_en,        // Ramp replaces captured audio
    input  logic [BIST_VAL_W-1:0] rf_bist_start_val,
    input  logic [BIST_VAL_W-1:0] rf_bist_up_limit,
    input  logic [BIST_INC_W-1:0] rf_bist_inc,
    output logic [FRAME_W-1:0]    i2si_data,
    output logic                  i2si_rts,
    input  logic                  i2si_rtr,
    output logic                  ro_fifo_overrun
);

    logic               sck_rise;                   // Synchronizer to deserializer
    logic               ws;
    logic               sd;
    logic [FRAME_W-1:0] cap_data;                   // Deserializer to frame source
    logic               cap_valid;
    logic [FRAME_W-1:0] src_data;                   // Frame source to FIFO
    logic               src_rts;
    logic               src_rtr;

    i2si_pin_sync i2si_pin_sync_i (
        .clk               (clk),
        .rst               (rst),
        .i2si_sck          (i2si_sck),
        .i2si_ws           (i2si_ws),
        .i2si_sd           (i2si_sd),
        .sck_rise          (sck_rise),
        .ws                (ws),
        .sd                (sd)
    );

    i2si_deserializer i2si_deserializer_i (
        .clk               (clk),
        .rst               (rst),
        .sck_rise          (sck_rise),
        .ws                (ws),
        .sd                (sd),
        .rf_i2si_en        (rf_i2si_en),
        .cap_data          (cap_data),
        .cap_valid         (cap_valid)
    );

    i2si_frame_source i2si_frame_source_i (
        .clk               (clk),
        .rst               (rst),
        .rf_bist_en        (rf_bist_en),
        .rf_bist_start_val (rf_bist_start_val),
        .rf_bist_up_limit  (rf_bist_up_limit),
        .rf_bist_inc       (rf_bist_inc),
        .cap_data          (cap_data),
        .cap_valid         (cap_valid),
        .src_rtr           (src_rtr),
        .src_data          (src_data),
        .src_rts           (src_rts),
        .ro_fifo_overrun   (ro_fifo_overrun)
    );

    i2si_fifo i2si_fifo_i (
        .clk               (clk),
        .rst               (rst),
        .src_data          (src_data),
        .src_rts           (src_rts),
        .src_rtr           (src_rtr),
        .i2si_data         (i2si_data),
        .i2si_rts          (i2si_rts),
        .i2si_rtr          (i2si_rtr)
    );

endmodule

// File: source/i2si_audio_pkg.sv
package i2si_audio_pkg;

    // One channel sample as carried on the I2S data line
    localparam int SAMPLE_W = 16;                   // Bits per channel, MSB first on the wire

    // Stereo frame as stored in the FIFO and sent downstream
    // Left sample sits in the upper half, right sample in the lower half
    localparam int FRAME_W = 2 * SAMPLE_W;          // Bits per stereo frame

endpackage

// File: source/i2si_ctrl_pkg.sv
package i2si_ctrl_pkg;

    // Self-test ramp generator
    localparam int BIST_VAL_W = 12;                 // Ramp start, limit and current value
    localparam int BIST_INC_W = 8;                  // Ramp step size

    // Frame buffer sizing
    // Pointers wrap naturally, so the depth is kept a power of two
    localparam int FIFO_DEPTH = 8;                  // Frames held
    localparam int FIFO_PTR_W = 3;                  // log2 of FIFO_DEPTH

endpackage

// File: source/i2si_deserializer.sv
`timescale 1ns/1ps

module i2si_deserializer
    import i2si_audio_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               sck_rise,            // Bit strobe from the pin synchronizer
    input  logic               ws,                  // 0 = left channel, 1 = right channel
    input  logic               sd,                  // Serial data bit
    input  logic               rf_i2si_en,          // Capture enable
    output logic [FRAME_W-1:0] cap_data,            // Left sample in the upper half
    output logic               cap_valid            // One-cycle pulse per finished frame
);

    logic                armed;                     // Seen a ws fall while enabled
    logic                ws_prev;                   // ws taken on the previous bit strobe
    logic [SAMPLE_W-1:0] shift_q;                   // Bits of the sample in progress
    logic [SAMPLE_W-1:0] left_q;                    // Finished left sample
    logic [SAMPLE_W-1:0] sample;                    // Shift register with the current bit
    logic                ws_fall;
    logic                ws_rise;
    logic                close_left;
    logic                close_right;

    // Philips framing has a one-bit delay, so the bit taken on the strobe
    // where ws changes is still the LSB of the sample that just ended
    assign sample      = {shift_q[SAMPLE_W-2:0], sd};
    assign ws_fall     = sck_rise & ws_prev & ~ws;
    assign ws_rise     = sck_rise & ~ws_prev & ws;
    assign close_left  = armed & ws_rise;
    assign close_right = armed & ws_fall;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            armed     <= 1'b0;
            ws_prev   <= 1'b0;                      // A real high must be seen before a fall
            cap_valid <= 1'b0;
        end
        else
        begin
            cap_valid <= rf_i2si_en & close_right;

            if (sck_rise)
            begin
                ws_prev <= ws;                      // Tracked even while disabled
            end

            if (!rf_i2si_en)
            begin
                armed <= 1'b0;                      // Partial frame is thrown away
            end
            else if (ws_fall)
            begin
                armed <= 1'b1;                      // Next bit is the left MSB
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            shift_q <= sample;
        end

        if (close_left)
        begin
            left_q <= sample;
        end

        if (close_right)
        begin
            cap_data <= {left_q, sample};
        end
    end

    // Strobes come at least three system clocks apart, so a frame pulse
    // must never be stretched over two cycles
    a_cap_valid_single : assert property (
        @(posedge clk) disable iff (!rst)
        cap_valid |=> !cap_valid
    );

endmodule

// File: source/i2si_fifo.sv
`timescale 1ns/1ps

module i2si_fifo
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [FRAME_W-1:0] src_data,
    input  logic               src_rts,
    output logic               src_rtr,             // High while not full
    output logic [FRAME_W-1:0] i2si_data,           // Head of the buffer, registered
    output logic               i2si_rts,            // Buffer holds at least one frame
    input  logic               i2si_rtr
);

    logic [FRAME_W-1:0]    mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;                  // Next free slot
    logic [FIFO_PTR_W-1:0] rd_ptr;                  // Slot shown on i2si_data
    logic [FIFO_PTR_W-1:0] head_ptr;                // Head slot after this cycle
    logic [FIFO_PTR_W:0]   count;                   // Frames stored, 0 to FIFO_DEPTH
    logic [FIFO_PTR_W:0]   count_next;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full     = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign src_rtr  = ~full;
    assign push     = src_rts & ~full;
    assign pop      = i2si_rts & i2si_rtr;
    assign head_ptr = pop ? rd_ptr + 1'b1 : rd_ptr;

    always_comb
    begin
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;            // Idle, or write and read together
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            i2si_rts <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            count    <= count_next;
            i2si_rts <= (count_next != '0);
        end
    end

    // The output register is loaded with whatever will be at the head next
    // cycle. When the new frame is the only one left it bypasses the array
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= src_data;
        end

        if (push && (wr_ptr == head_ptr))
        begin
            i2si_data <= src_data;
        end
        else
        begin
            i2si_data <= mem[head_ptr];
        end
    end

    // A write must never land on a slot that still holds an unread frame
    a_no_write_full : assert property (
        @(posedge clk) disable iff (!rst)
        push |-> (count == '0 || wr_ptr != rd_ptr)
    );

    // The registered rts must never run ahead of the stored count
    a_no_read_empty : assert property (
        @(posedge clk) disable iff (!rst)
        pop |-> (count != '0)
    );

endmodule

// File: source/i2si_frame_source.sv
`timescale 1ns/1ps

module i2si_frame_source
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rf_bist_en,        // 1 = ramp, 0 = captured audio
    input  logic [BIST_VAL_W-1:0] rf_bist_start_val,
    input  logic [BIST_VAL_W-1:0] rf_bist_up_limit,
    input  logic [BIST_INC_W-1:0] rf_bist_inc,
    input  logic [FRAME_W-1:0]    cap_data,          // Frame from the deserializer
    input  logic                  cap_valid,         // Frame strobe, cannot be stalled
    input  logic                  src_rtr,           // FIFO has room
    output logic [FRAME_W-1:0]    src_data,
    output logic                  src_rts,
    output logic                  ro_fifo_overrun    // Pulse per dropped capture frame
);

    logic [BIST_VAL_W-1:0] ramp_val;                 // Current ramp value
    logic [BIST_VAL_W:0]   ramp_sum;                 // One extra bit to catch the wrap
    logic [SAMPLE_W-1:0]   ramp_sample;              // Ramp value widened to a sample
    logic                  ramp_xfer;

    assign ramp_sum    = {1'b0, ramp_val}
                       + {{(BIST_VAL_W + 1 - BIST_INC_W){1'b0}}, rf_bist_inc};
    assign ramp_sample = {{(SAMPLE_W - BIST_VAL_W){1'b0}}, ramp_val};
    assign ramp_xfer   = src_rts & src_rtr;

    // Source select
    always_comb
    begin
        if (rf_bist_en)
        begin
            src_data = {ramp_sample, ramp_sample};   // Same value on both channels
            src_rts  = 1'b1;                         // Ramp always has a word ready
        end
        else
        begin
            src_data = cap_data;
            src_rts  = cap_valid;
        end
    end

    // Ramp generator, restarts from the start value when the next step
    // would pass the upper limit
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ramp_val <= '0;
        end
        else if (!rf_bist_en)
        begin
            ramp_val <= rf_bist_start_val;           // Preload while idle
        end
        else if (ramp_xfer)
        begin
            if (ramp_sum > {1'b0, rf_bist_up_limit})
            begin
                ramp_val <= rf_bist_start_val;
            end
            else
            begin
                ramp_val <= ramp_sum[BIST_VAL_W-1:0];
            end
        end
    end

    // Audio cannot wait, so a frame offered to a full FIFO is lost
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ro_fifo_overrun <= 1'b0;
        end
        else
        begin
            ro_fifo_overrun <= ~rf_bist_en & cap_valid & ~src_rtr;
        end
    end

    a_ramp_in_range : assert property (
        @(posedge clk) disable iff (!rst)
        (rf_bist_en && $past(rf_bist_en) && rf_bist_start_val <= rf_bist_up_limit)
            |-> (ramp_val <= rf_bist_up_limit)
    );

endmodule

// File: source/i2si_pin_sync.sv
`timescale 1ns/1ps

module i2si_pin_sync (
    input  logic clk,
    input  logic rst,
    input  logic i2si_sck,                          // Asynchronous bit clock pin
    input  logic i2si_ws,                           // Asynchronous word select pin
    input  logic i2si_sd,                           // Asynchronous serial data pin
    output logic sck_rise,                          // One-cycle pulse per bit clock rising edge
    output logic ws,                                // Word select, aligned to sck_rise
    output logic sd                                 // Serial data, aligned to sck_rise
);

    logic [2:0] sck_q;                              // Two sync stages plus the edge stage
    logic [1:0] ws_q;
    logic [1:0] sd_q;

    // All three pins share the same synchronizer depth so that ws and sd
    // are sampled on the same system clock as the sck edge they belong to
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sck_q    <= '0;
            ws_q     <= '0;
            sd_q     <= '0;
            sck_rise <= 1'b0;
            ws       <= 1'b0;
            sd       <= 1'b0;
        end
        else
        begin
            sck_q    <= {sck_q[1:0], i2si_sck};
            ws_q     <= {ws_q[0], i2si_ws};
            sd_q     <= {sd_q[0], i2si_sd};
            sck_rise <= sck_q[1] & ~sck_q[2];       // Low-to-high on synchronized sck
            ws       <= ws_q[1];                    // Extra stage to line up with sck_rise
            sd       <= sd_q[1];
        end
    end

endmodule

// File: testbench/tb_i2si_model.svh
`ifndef TB_I2SI_MODEL_SVH
`define TB_I2SI_MODEL_SVH

// One I2S bit period of 8 system clocks, data and word select change while sck falls
task automatic send_slot(input logic ws_bit, input logic sd_bit);
    @(posedge clk);
    i2si_sck <= 1'b0;
    i2si_ws  <= ws_bit;
    i2si_sd  <= sd_bit;
    repeat (4) @(posedge clk);
    i2si_sck <= 1'b1;                               // Receiver samples on this rise
    repeat (3) @(posedge clk);
endtask

// Sends every frame in tx_q with Philips framing and one-bit delay
task automatic send_frames();
    logic               last_lsb;
    logic [FRAME_W-1:0] frame;
    last_lsb = 1'b0;
    send_slot(1'b1, 1'b0);                          // Lead-in so the first frame opens with a ws fall
    foreach (tx_q[i])
    begin
        frame = tx_q[i];
        send_slot(1'b0, last_lsb);                  // LSB of the previous right sample
        for (int b = SAMPLE_W - 1; b >= 1; b--)
            send_slot(1'b0, frame[SAMPLE_W + b]);
        send_slot(1'b1, frame[SAMPLE_W]);           // Left LSB with ws already high
        for (int b = SAMPLE_W - 1; b >= 1; b--)
            send_slot(1'b1, frame[b]);
        last_lsb = frame[0];
    end
    send_slot(1'b0, last_lsb);                      // Closing ws fall ends the last right sample
    repeat (16) @(posedge clk);
endtask

task automatic load_random(input int frames);
    tx_q.delete();
    repeat (frames)
        tx_q.push_back($urandom);
endtask

// Ramp rule, restart from the start value when the next step passes the limit
function automatic int ramp_next(input int v, input int start, input int inc, input int limit);
    if (v + inc > limit)
        return start;
    return v + inc;
endfunction

function automatic logic [FRAME_W-1:0] ramp_frame(input int v);
    logic [SAMPLE_W-1:0] s;
    s = SAMPLE_W'(v);
    return {s, s};                                  // Same value on both channels
endfunction

task automatic check_value(input string name, input logic [FRAME_W-1:0] got,
                           input logic [FRAME_W-1:0] exp);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < limit)
    begin
        @(negedge clk);
        waited++;
    end
    if (exp_q.size() != 0)
    begin
        $display("timeout: %0d expected words never came out within %0d cycles",
                 exp_q.size(), limit);
        errors++;
        exp_q.delete();
    end
endtask

`endif

// File: testbench/tb_i2si.sv
`timescale 1ns/1ps

module tb_i2si
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  i2si_sck;
    logic                  i2si_ws;
    logic                  i2si_sd;
    logic                  rf_i2si_en;
    logic                  rf_bist_en;
    logic [BIST_VAL_W-1:0] rf_bist_start_val;
    logic [BIST_VAL_W-1:0] rf_bist_up_limit;
    logic [BIST_INC_W-1:0] rf_bist_inc;
    logic [FRAME_W-1:0]    i2si_data;
    logic                  i2si_rts;
    logic                  i2si_rtr;
    logic                  ro_fifo_overrun;

    logic [FRAME_W-1:0]    exp_q[$];                // Words still due on the output, in order
    logic [FRAME_W-1:0]    tx_q[$];                 // Frames for the next transmitter run
    logic                  rtr_hold;                // Forces i2si_rtr low
    logic                  overrun_prev;
    int                    errors;
    int                    tests_ok;
    int                    tests_bad;
    int                    overrun_pulses;
    int                    overrun_cycles;

    `include "tb_i2si_model.svh"

    task automatic end_test(input string name, input int start_errors);
        if (errors == start_errors)
        begin
            tests_ok++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            check_value("i2si_rts", i2si_rts, 1'b0);
            check_value("ro_fifo_overrun", ro_fifo_overrun, 1'b0);
        end
    endtask

    i2si i2si_i (
        .clk               (clk),
        .rst               (rst),
        .i2si_sck          (i2si_sck),
        .i2si_ws           (i2si_ws),
        .i2si_sd           (i2si_sd),
        .rf_i2si_en        (rf_i2si_en),
        .rf_bist_en        (rf_bist_en),
        .rf_bist_start_val (rf_bist_start_val),
        .rf_bist_up_limit  (rf_bist_up_limit),
        .rf_bist_inc       (rf_bist_inc),
        .i2si_data         (i2si_data),
        .i2si_rts          (i2si_rts),
        .i2si_rtr          (i2si_rtr),
        .ro_fifo_overrun   (ro_fifo_overrun)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Compares each word read and picks the next i2si_rtr
    always @(posedge clk)
    begin : monitor
        logic coin;
        coin = $urandom_range(1, 0);                // Drawn every cycle to keep the sequence fixed
        if (i2si_rts && i2si_rtr)
        begin
            if (exp_q.size() == 0)
            begin
                $display("unexpected word %h read at %0t with nothing expected", i2si_data, $time);
                errors++;
            end
            else
                check_value("i2si_data", i2si_data, exp_q.pop_front());
        end
        i2si_rtr <= coin && !rtr_hold && (exp_q.size() != 0);
    end

    always @(posedge clk)
    begin
        if (ro_fifo_overrun)
            overrun_cycles++;
        if (ro_fifo_overrun && !overrun_prev)
            overrun_pulses++;
        overrun_prev = ro_fifo_overrun;
    end

    initial
    begin
        int start_errors;
        int pulses_before;
        int cycles_before;
        int v;
        void'($urandom(16));
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        overrun_pulses = 0;
        overrun_cycles = 0;
        overrun_prev = 1'b0;
        rtr_hold = 1'b0;
        rst <= 1'b0;
        i2si_sck <= 1'b1;
        i2si_ws <= 1'b0;
        i2si_sd <= 1'b0;
        rf_i2si_en <= 1'b0;
        rf_bist_en <= 1'b0;
        rf_bist_start_val <= '0;
        rf_bist_up_limit <= '0;
        rf_bist_inc <= '0;
        i2si_rtr <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        // Traffic on the pins with capture off
        start_errors = errors;
        check_value("i2si_rts", i2si_rts, 1'b0);
        check_value("ro_fifo_overrun", ro_fifo_overrun, 1'b0);
        load_random(2);
        fork
            send_frames();
            check_quiet(50 + (2 + 2 * FRAME_W) * 8);    // Both frames plus a quiet tail
        join
        end_test("quiet while disabled", start_errors);

        // Capture with random back-pressure
        start_errors = errors;
        @(negedge clk);
        pulses_before = overrun_pulses;
        load_random(20);
        foreach (tx_q[i])
            exp_q.push_back(tx_q[i]);
        @(posedge clk);
        rf_i2si_en <= 1'b1;
        send_frames();
        wait_drained(2000);
        repeat (2) @(posedge clk);
        check_value("i2si_rts", i2si_rts, 1'b0);
        check_value("overrun pulses", overrun_pulses - pulses_before, 0);
        rf_i2si_en <= 1'b0;
        end_test("capture", start_errors);

        // Enable raised in the middle of the second frame
        start_errors = errors;
        @(negedge clk);
        load_random(4);
        exp_q.push_back(tx_q[2]);
        exp_q.push_back(tx_q[3]);
        fork
            send_frames();
            begin
                repeat (400) @(posedge clk);
                rf_i2si_en <= 1'b1;
            end
        join
        wait_drained(2000);
        repeat (2) @(posedge clk);
        check_value("i2si_rts", i2si_rts, 1'b0);
        rf_i2si_en <= 1'b0;
        end_test("enable gating", start_errors);

        // Output held off until the buffer overflows
        start_errors = errors;
        @(negedge clk);
        rtr_hold = 1'b1;
        pulses_before = overrun_pulses;
        cycles_before = overrun_cycles;
        load_random(12);
        for (int i = 0; i < FIFO_DEPTH; i++)
            exp_q.push_back(tx_q[i]);
        @(posedge clk);
        rf_i2si_en <= 1'b1;
        send_frames();
        @(negedge clk);
        check_value("overrun pulses", overrun_pulses - pulses_before, 12 - FIFO_DEPTH);
        check_value("overrun cycles", overrun_cycles - cycles_before, 12 - FIFO_DEPTH);
        rtr_hold = 1'b0;
        wait_drained(2000);
        repeat (2) @(posedge clk);
        check_value("i2si_rts", i2si_rts, 1'b0);
        rf_i2si_en <= 1'b0;
        end_test("overrun", start_errors);

        // Self-test ramp from 100 in steps of 7 up to 150
        start_errors = errors;
        @(negedge clk);
        pulses_before = overrun_pulses;
        v = 100;
        for (int i = 0; i < 30; i++)
        begin
            exp_q.push_back(ramp_frame(v));
            v = ramp_next(v, 100, 7, 150);
        end
        @(posedge clk);
        rf_bist_start_val <= 12'd100;
        rf_bist_inc <= 8'd7;
        rf_bist_up_limit <= 12'd150;
        @(posedge clk);
        rf_bist_en <= 1'b1;
        wait_drained(2000);
        @(negedge clk);
        check_value("overrun pulses", overrun_pulses - pulses_before, 0);
        @(posedge clk);
        rf_bist_en <= 1'b0;
        end_test("ramp", start_errors);

        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
